//--- source/lpif_link_defs.svh
/*
  Size definitions for the two-lane link layer
  Lane geometry, user payload, receive FIFO depth and counter widths
*/
`ifndef LPIF_LINK_DEFS_SVH
`define LPIF_LINK_DEFS_SVH

// PHY lane geometry
`define LANE_WIDTH   40
`define NUM_LANES    2

// User payload bits carried per frame
`define DATA_WIDTH   64

// Receive FIFO entries, a power of two
`define FIFO_DEPTH   4

// Credit count width, wide enough for the initial credit
`define CREDIT_WIDTH 4

// Sync delay values in clock cycles
`define DELAY_WIDTH  16

`endif

//--- source/lpif_link_pkg.sv
/*
  Shared types of the link layer
  Lane words, user fields, counters and the sync state encoding
*/
`default_nettype none

`include "lpif_link_defs.svh"

package lpif_link_pkg;

  typedef logic [`LANE_WIDTH-1:0]   lane_word_t;
  typedef logic [`DATA_WIDTH-1:0]   user_data_t;
  typedef logic [1:0]               protid_t;
  typedef logic [`CREDIT_WIDTH-1:0] credit_t;
  typedef logic [`DELAY_WIDTH-1:0]  delay_t;

  // Bring-up sequence, transmit side first
  typedef enum logic [2:0] {
    SYNC_IDLE    = 3'd0,
    SYNC_TX_WAIT = 3'd1,
    SYNC_TX_UP   = 3'd2,
    SYNC_RX_WAIT = 3'd3,
    SYNC_LINK_UP = 3'd4
  } sync_state_t;

endpackage

`default_nettype wire

//--- source/delay_timer.sv
/*
  Programmable delay timer
  Down-counter with a single-cycle expiry pulse, idle between loads
*/
`timescale 1ns/1ps
`default_nettype none

module delay_timer (
  input  wire                          clk_wr,
  input  wire                          rst_n,
  input  wire                          timer_load,
  input  wire  lpif_link_pkg::delay_t  timer_value,
  output logic                         timer_done
);

  lpif_link_pkg::delay_t count_q;
  logic                  busy_q;

  // A load always restarts the count, even mid-run
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      busy_q  <= 1'b0;
    end else if (timer_load) begin
      count_q <= timer_value;
      busy_q  <= 1'b1;
    end else if (busy_q) begin
      if (count_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Expiry seen for one cycle, then idle
  assign timer_done = busy_q && (count_q == '0);

endmodule

`default_nettype wire

//--- source/link_sync_fsm.sv
/*
  Link bring-up sequencer
  Brings transmit online after delay Y, then receive after delay X
*/
`timescale 1ns/1ps
`default_nettype none

module link_sync_fsm (
  input  wire                          clk_wr,
  input  wire                          rst_n,
  input  wire                          tx_online,
  input  wire                          rx_online,
  input  wire  lpif_link_pkg::delay_t  delay_x_value,
  input  wire  lpif_link_pkg::delay_t  delay_y_value,
  input  wire                          timer_done,
  output logic                         timer_load,
  output lpif_link_pkg::delay_t        timer_value,
  output logic                         tx_link_up,
  output logic                         rx_link_up
);

  lpif_link_pkg::sync_state_t state_q;
  lpif_link_pkg::sync_state_t state_d;
  logic                       rx_start;
  logic                       rx_side;

  // Receive waits for the registered transmit status, not the state
  assign rx_start = tx_link_up && rx_online;
  assign rx_side  = (state_q == lpif_link_pkg::SYNC_RX_WAIT) ||
                    (state_q == lpif_link_pkg::SYNC_LINK_UP);

  always_comb begin
    state_d = state_q;
    case (state_q)
      lpif_link_pkg::SYNC_IDLE: begin
        if (tx_online) state_d = lpif_link_pkg::SYNC_TX_WAIT;
      end
      lpif_link_pkg::SYNC_TX_WAIT: begin
        if (timer_done) state_d = lpif_link_pkg::SYNC_TX_UP;
      end
      lpif_link_pkg::SYNC_TX_UP: begin
        if (rx_start) state_d = lpif_link_pkg::SYNC_RX_WAIT;
      end
      lpif_link_pkg::SYNC_RX_WAIT: begin
        if (timer_done) state_d = lpif_link_pkg::SYNC_LINK_UP;
      end
      default: state_d = state_q;
    endcase
    // Losing either side takes the link down
    if (!tx_online || (rx_side && !rx_online)) begin
      state_d = lpif_link_pkg::SYNC_IDLE;
    end
  end

  // One timer serves both delays
  assign timer_load  = (state_q == lpif_link_pkg::SYNC_IDLE &&
                        state_d == lpif_link_pkg::SYNC_TX_WAIT) ||
                       (state_q == lpif_link_pkg::SYNC_TX_UP &&
                        state_d == lpif_link_pkg::SYNC_RX_WAIT);
  assign timer_value = (state_q == lpif_link_pkg::SYNC_IDLE) ? delay_y_value : delay_x_value;

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= lpif_link_pkg::SYNC_IDLE;
      tx_link_up <= 1'b0;
      rx_link_up <= 1'b0;
    end else begin
      state_q    <= state_d;
      tx_link_up <= (state_q == lpif_link_pkg::SYNC_TX_UP) || rx_side;
      rx_link_up <= (state_q == lpif_link_pkg::SYNC_LINK_UP);
    end
  end

endmodule

`default_nettype wire

//--- source/tx_frame_packer.sv
/*
  Transmit side of the link
  Upstream credit count, sticky credit error, registered two-lane framing
*/
`timescale 1ns/1ps
`default_nettype none

module tx_frame_packer (
  input  wire                              clk_wr,
  input  wire                              rst_n,
  input  wire                              tx_link_up,
  input  wire  lpif_link_pkg::credit_t     init_upstream_credit,
  input  wire                              ustrm_valid,
  input  wire  lpif_link_pkg::protid_t     ustrm_protid,
  input  wire  lpif_link_pkg::user_data_t  ustrm_data,
  input  wire                              credit_pending,
  input  wire                              credit_return,
  output logic                             credit_sent,
  output lpif_link_pkg::credit_t           ustrm_credit,
  output logic                             credit_err,
  output lpif_link_pkg::lane_word_t        tx_phy0,
  output lpif_link_pkg::lane_word_t        tx_phy1
);

  lpif_link_pkg::credit_t    credit_q;
  lpif_link_pkg::credit_t    credit_base;
  lpif_link_pkg::credit_t    credit_next;
  lpif_link_pkg::protid_t    protid_sel;
  lpif_link_pkg::user_data_t data_sel;
  logic                      tx_link_up_q;
  logic                      link_rise;
  logic                      accept;

  ////////////////////////////////////////////////////////////////////////////
  // Credit accounting

  assign link_rise = tx_link_up && !tx_link_up_q;

  // Initial credit visible in the very cycle the link comes up
  assign credit_base  = !tx_link_up ? '0 :
                        link_rise   ? init_upstream_credit : credit_q;
  assign ustrm_credit = credit_base;

  assign accept      = tx_link_up && ustrm_valid && (credit_base != '0);
  assign credit_sent = tx_link_up && credit_pending;

  always_comb begin
    credit_next = credit_base;
    if (credit_return && !accept) begin
      credit_next = credit_base + 1'b1;
    end else if (!credit_return && accept) begin
      credit_next = credit_base - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Frame build

  // Idle frames carry zero payload
  assign protid_sel = accept ? ustrm_protid : '0;
  assign data_sel   = accept ? ustrm_data : '0;

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_link_up_q <= 1'b0;
      credit_q     <= '0;
      credit_err   <= 1'b0;
      tx_phy0      <= '0;
      tx_phy1      <= '0;
    end else begin
      tx_link_up_q <= tx_link_up;
      credit_q     <= tx_link_up ? credit_next : '0;
      // Word offered without credit is lost
      if (ustrm_valid && !accept) begin
        credit_err <= 1'b1;
      end
      if (!tx_link_up) begin
        tx_phy0 <= '0;
        tx_phy1 <= '0;
      end else begin
        // Strobe, credit return, valid, protid, data low
        tx_phy0 <= {1'b1, credit_pending, accept, protid_sel, data_sel[34:0]};
        // Marker reserved, then data high
        tx_phy1 <= {1'b0, 10'b0, data_sel[63:35]};
      end
    end
  end

endmodule

`default_nettype wire

//--- source/rx_frame_unpacker.sv
/*
  Receive side of the link
  Lane capture, receive FIFO, returned-credit detect, pending-credit count
*/
`timescale 1ns/1ps
`default_nettype none

`include "lpif_link_defs.svh"

module rx_frame_unpacker (
  input  wire                              clk_wr,
  input  wire                              rst_n,
  input  wire                              rx_link_up,
  input  wire  lpif_link_pkg::lane_word_t  rx_phy0,
  input  wire  lpif_link_pkg::lane_word_t  rx_phy1,
  input  wire                              dstrm_pop,
  input  wire                              credit_sent,
  output logic                             credit_pending,
  output logic                             credit_return,
  output logic                             dstrm_valid,
  output lpif_link_pkg::protid_t           dstrm_protid,
  output lpif_link_pkg::user_data_t        dstrm_data
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);

  logic [`NUM_LANES-1:0][`LANE_WIDTH-1:0] rx_lanes_q;
  logic [PTR_W:0]                         wr_ptr_q;
  logic [PTR_W:0]                         rd_ptr_q;
  lpif_link_pkg::protid_t                 protid_mem [`FIFO_DEPTH];
  lpif_link_pkg::user_data_t              data_mem   [`FIFO_DEPTH];
  lpif_link_pkg::credit_t                 pend_q;
  logic                                   frame_ok;
  logic                                   push;
  logic                                   pop;
  logic                                   full;
  logic                                   empty;

  ////////////////////////////////////////////////////////////////////////////
  // Lane capture and frame decode

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_lanes_q <= '0;
    end else begin
      rx_lanes_q <= {rx_phy1, rx_phy0};
    end
  end

  // Strobe qualifies the whole frame
  assign frame_ok      = rx_link_up && rx_lanes_q[0][39];
  assign credit_return = frame_ok && rx_lanes_q[0][38];
  assign push          = frame_ok && rx_lanes_q[0][37] && !full;

  ////////////////////////////////////////////////////////////////////////////
  // Receive FIFO

  // Extra pointer bit tells full from empty
  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                 (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

  assign dstrm_valid  = !empty;
  assign pop          = dstrm_pop && dstrm_valid;
  assign dstrm_protid = protid_mem[rd_ptr_q[PTR_W-1:0]];
  assign dstrm_data   = data_mem[rd_ptr_q[PTR_W-1:0]];

  always_ff @(posedge clk_wr) begin
    if (push) begin
      protid_mem[wr_ptr_q[PTR_W-1:0]] <= rx_lanes_q[0][36:35];
      data_mem[wr_ptr_q[PTR_W-1:0]]   <= {rx_lanes_q[1][28:0], rx_lanes_q[0][34:0]};
    end
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pending credits, one per pop until sent back

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= '0;
    end else if (pop && !credit_sent) begin
      pend_q <= pend_q + 1'b1;
    end else if (!pop && credit_sent) begin
      pend_q <= pend_q - 1'b1;
    end
  end

  assign credit_pending = (pend_q != '0);

endmodule

`default_nettype wire

//--- source/lpif_link_top.sv
/*
  Link layer top over a two-lane PHY
  Sync sequencer with delay timer, transmit packer and receive unpacker
*/
`timescale 1ns/1ps
`default_nettype none

module lpif_link_top (
  input  wire                              clk_wr,
  input  wire                              rst_n,

  // Sync control
  input  wire                              tx_online,
  input  wire                              rx_online,
  input  wire  lpif_link_pkg::delay_t      delay_x_value,
  input  wire  lpif_link_pkg::delay_t      delay_y_value,

  input  wire  lpif_link_pkg::credit_t     init_upstream_credit,

  // PHY lanes
  output lpif_link_pkg::lane_word_t        tx_phy0,
  output lpif_link_pkg::lane_word_t        tx_phy1,
  input  wire  lpif_link_pkg::lane_word_t  rx_phy0,
  input  wire  lpif_link_pkg::lane_word_t  rx_phy1,

  // Upstream user side
  input  wire                              ustrm_valid,
  input  wire  lpif_link_pkg::protid_t     ustrm_protid,
  input  wire  lpif_link_pkg::user_data_t  ustrm_data,
  output lpif_link_pkg::credit_t           ustrm_credit,
  output logic                             credit_err,

  // Downstream user side
  output logic                             dstrm_valid,
  output lpif_link_pkg::protid_t           dstrm_protid,
  output lpif_link_pkg::user_data_t        dstrm_data,
  input  wire                              dstrm_pop,

  // Status
  output logic                             tx_link_up,
  output logic                             rx_link_up
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal wires

  logic                  timer_load;
  lpif_link_pkg::delay_t timer_value;
  logic                  timer_done;
  logic                  credit_pending;
  logic                  credit_return;
  logic                  credit_sent;

  ////////////////////////////////////////////////////////////////////////////
  // Bring-up

  delay_timer delay_timer_i (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .timer_load  (timer_load),
    .timer_value (timer_value),
    .timer_done  (timer_done)
  );

  link_sync_fsm link_sync_fsm_i (
    .clk_wr        (clk_wr),
    .rst_n         (rst_n),
    .tx_online     (tx_online),
    .rx_online     (rx_online),
    .delay_x_value (delay_x_value),
    .delay_y_value (delay_y_value),
    .timer_done    (timer_done),
    .timer_load    (timer_load),
    .timer_value   (timer_value),
    .tx_link_up    (tx_link_up),
    .rx_link_up    (rx_link_up)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Data path, credits loop through the far side

  tx_frame_packer tx_frame_packer_i (
    .clk_wr               (clk_wr),
    .rst_n                (rst_n),
    .tx_link_up           (tx_link_up),
    .init_upstream_credit (init_upstream_credit),
    .ustrm_valid          (ustrm_valid),
    .ustrm_protid         (ustrm_protid),
    .ustrm_data           (ustrm_data),
    .credit_pending       (credit_pending),
    .credit_return        (credit_return),
    .credit_sent          (credit_sent),
    .ustrm_credit         (ustrm_credit),
    .credit_err           (credit_err),
    .tx_phy0              (tx_phy0),
    .tx_phy1              (tx_phy1)
  );

  rx_frame_unpacker rx_frame_unpacker_i (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .rx_link_up     (rx_link_up),
    .rx_phy0        (rx_phy0),
    .rx_phy1        (rx_phy1),
    .dstrm_pop      (dstrm_pop),
    .credit_sent    (credit_sent),
    .credit_pending (credit_pending),
    .credit_return  (credit_return),
    .dstrm_valid    (dstrm_valid),
    .dstrm_protid   (dstrm_protid),
    .dstrm_data     (dstrm_data)
  );

endmodule

`default_nettype wire

//--- verif/tb_lpif_link.sv
/*
  Testbench for the two-lane link layer
  PHY loopback, file-driven send and pop commands, sync and credit checks
*/
`timescale 1ns/1ps
`default_nettype none

module tb_lpif_link;

  logic                      clk_wr;
  logic                      rst_n;
  logic                      tx_online;
  logic                      rx_online;
  lpif_link_pkg::delay_t     delay_x_value;
  lpif_link_pkg::delay_t     delay_y_value;
  lpif_link_pkg::credit_t    init_upstream_credit;
  logic                      ustrm_valid;
  lpif_link_pkg::protid_t    ustrm_protid;
  lpif_link_pkg::user_data_t ustrm_data;
  logic                      dstrm_pop;
  lpif_link_pkg::lane_word_t tx_phy0;
  lpif_link_pkg::lane_word_t tx_phy1;
  lpif_link_pkg::credit_t    ustrm_credit;
  logic                      credit_err;
  logic                      dstrm_valid;
  lpif_link_pkg::protid_t    dstrm_protid;
  lpif_link_pkg::user_data_t dstrm_data;
  logic                      tx_link_up;
  logic                      rx_link_up;

  // Parsed commands and the reference model
  logic [7:0]  cmd_q    [$];
  logic [1:0]  pid_q    [$];
  logic [63:0] data_q   [$];
  logic [1:0]  ref_pid  [$];
  logic [63:0] ref_data [$];
  int          cfg_dx;
  int          cfg_dy;
  int          cfg_credit;
  int          credit_model;
  logic        err_model;
  int          watchdog_cycles = 0;
  logic [16:0] lfsr_state;

  // Lanes looped straight back into the receiver
  lpif_link_top uut (
    .clk_wr               (clk_wr),
    .rst_n                (rst_n),
    .tx_online            (tx_online),
    .rx_online            (rx_online),
    .delay_x_value        (delay_x_value),
    .delay_y_value        (delay_y_value),
    .init_upstream_credit (init_upstream_credit),
    .tx_phy0              (tx_phy0),
    .tx_phy1              (tx_phy1),
    .rx_phy0              (tx_phy0),
    .rx_phy1              (tx_phy1),
    .ustrm_valid          (ustrm_valid),
    .ustrm_protid         (ustrm_protid),
    .ustrm_data           (ustrm_data),
    .ustrm_credit         (ustrm_credit),
    .credit_err           (credit_err),
    .dstrm_valid          (dstrm_valid),
    .dstrm_protid         (dstrm_protid),
    .dstrm_data           (dstrm_data),
    .dstrm_pop            (dstrm_pop),
    .tx_link_up           (tx_link_up),
    .rx_link_up           (rx_link_up)
  );

  initial begin
    clk_wr = 1'b0;
    forever #5 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking and helpers

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("tests failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic abort_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("tests failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_reset_outputs(input string when);
    check_value(tx_link_up, 1'b0, {"tx_link_up ", when});
    check_value(rx_link_up, 1'b0, {"rx_link_up ", when});
    check_value(dstrm_valid, 1'b0, {"dstrm_valid ", when});
    check_value(credit_err, 1'b0, {"credit_err ", when});
    check_value(ustrm_credit, 4'd0, {"ustrm_credit ", when});
    check_value(tx_phy0, 40'd0, {"tx_phy0 ", when});
    check_value(tx_phy1, 40'd0, {"tx_phy1 ", when});
  endtask

  // Only valid when the last sampled ustrm_valid was low
  task automatic check_idle_frame();
    check_value(tx_phy0[39], 1'b1, "idle frame strobe");
    check_value(tx_phy0[37], 1'b0, "idle frame valid bit");
    check_value(tx_phy1[39:29], 11'd0, "idle frame lane 1 upper bits");
  endtask

  // x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_next(input logic [16:0] state);
    lfsr_next = {state[15:0], state[16] ^ state[13]};
  endfunction

  task automatic insert_idle_gap();
    int gap;
    gap = 0;
    repeat (2) begin
      lfsr_state = lfsr_next(lfsr_state);
      gap = (gap << 1) | int'(lfsr_state[0]);
    end
    repeat (gap) @(negedge clk_wr);
  endtask

  task automatic load_stimulus();
    int          fd;
    int          c;
    int          r;
    logic        have_cfg;
    logic [1:0]  pid;
    logic [63:0] data;
    have_cfg = 1'b0;
    fd = $fopen("verif/lpif_link_stimulus.txt", "r");
    if (fd == 0) abort_run("cannot open verif/lpif_link_stimulus.txt");
    forever begin
      c = $fgetc(fd);
      while (c == " " || c == "\t" || c == "\n" || c == "\r") begin
        c = $fgetc(fd);
      end
      if (c == -1) break;
      if (c == "#") begin
        while (c != "\n" && c != -1) begin
          c = $fgetc(fd);
        end
      end else if (c == "C") begin
        r = $fscanf(fd, "%d %d %d", cfg_dx, cfg_dy, cfg_credit);
        if (r != 3) abort_run("configuration line in stimulus file is malformed");
        have_cfg = 1'b1;
      end else begin
        r = $fscanf(fd, "%h %h", pid, data);
        if (r != 2) abort_run("command line in stimulus file is malformed");
        cmd_q.push_back(c[7:0]);
        pid_q.push_back(pid);
        data_q.push_back(data);
      end
    end
    $fclose(fd);
    if (!have_cfg) abort_run("stimulus file has no configuration line");
  endtask

  // Edge count includes the edge that first samples the online input
  task automatic count_edges_to_rise(input logic rx_side, input int limit, output int edges);
    edges = 0;
    @(negedge clk_wr);
    while (!(rx_side ? rx_link_up : tx_link_up)) begin
      if (edges > limit) abort_run("link-up output never rose after online was raised");
      @(posedge clk_wr);
      edges = edges + 1;
      @(negedge clk_wr);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // User-side commands

  task automatic send_word(input logic [1:0] pid, input logic [63:0] data, input logic forced);
    check_value(ustrm_credit, credit_model, "credit before send");
    check_value(credit_err, err_model, "credit error before send");
    if (forced && credit_model != 0) abort_run("drain command issued while credits remain");
    @(posedge clk_wr);
    ustrm_valid  <= 1'b1;
    ustrm_protid <= pid;
    ustrm_data   <= data;
    @(posedge clk_wr);
    ustrm_valid <= 1'b0;
    @(negedge clk_wr);
    if (forced) begin
      err_model = 1'b1;
      check_value(tx_phy0[37], 1'b0, "frame valid bit after send at zero credit");
    end else begin
      credit_model = credit_model - 1;
      ref_pid.push_back(pid);
      ref_data.push_back(data);
      check_value(tx_phy0, {1'b1, 1'b0, 1'b1, pid, data[34:0]}, "lane 0 of sent frame");
      check_value(tx_phy1, {11'd0, data[63:35]}, "lane 1 of sent frame");
    end
    check_value(ustrm_credit, credit_model, "credit after send");
    check_value(credit_err, err_model, "credit error after send");
  endtask

  task automatic pop_word(input logic [1:0] pid, input logic [63:0] data);
    int waited;
    waited = 0;
    while (!dstrm_valid) begin
      if (waited == 20) abort_run("receive FIFO stayed empty while a word was expected");
      @(negedge clk_wr);
      waited = waited + 1;
    end
    if (ref_data.size() == 0) abort_run("pop command with no accepted word outstanding");
    check_value(dstrm_protid, pid, "popped protid against stimulus");
    check_value(dstrm_data, data, "popped data against stimulus");
    check_value(dstrm_protid, ref_pid.pop_front(), "popped protid against reference");
    check_value(dstrm_data, ref_data.pop_front(), "popped data against reference");
    @(posedge clk_wr);
    dstrm_pop <= 1'b1;
    @(posedge clk_wr);
    dstrm_pop <= 1'b0;
    // Credit comes back over the loopback after a few cycles
    credit_model = credit_model + 1;
    waited = 0;
    @(negedge clk_wr);
    while (ustrm_credit != credit_model[3:0]) begin
      if (waited == 20) abort_run("returned credit did not reach the expected count");
      @(negedge clk_wr);
      waited = waited + 1;
    end
    check_value(credit_err, err_model, "credit error after pop");
    check_idle_frame();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin : main_flow
    int edges;
    int idx;
    rst_n                = 1'b0;
    tx_online            = 1'b0;
    rx_online            = 1'b0;
    ustrm_valid          = 1'b0;
    ustrm_protid         = '0;
    ustrm_data           = '0;
    dstrm_pop            = 1'b0;
    lfsr_state           = 17'd91772;
    err_model            = 1'b0;
    load_stimulus();
    delay_x_value        = cfg_dx[15:0];
    delay_y_value        = cfg_dy[15:0];
    init_upstream_credit = cfg_credit[3:0];
    watchdog_cycles      = 40 + cfg_dx + cfg_dy + 40 * cmd_q.size();

    repeat (10) begin
      @(negedge clk_wr);
      check_reset_outputs("during reset");
    end
    @(posedge clk_wr);
    rst_n <= 1'b1;
    @(negedge clk_wr);
    check_reset_outputs("after reset");

    // Transmit side first, then receive
    @(posedge clk_wr);
    tx_online <= 1'b1;
    count_edges_to_rise(1'b0, cfg_dy + 10, edges);
    check_value(edges - 1, cfg_dy + 2, "edges from tx_online to tx_link_up");
    check_value(ustrm_credit, cfg_credit, "credit as tx_link_up rises");
    check_value(rx_link_up, 1'b0, "rx_link_up before rx_online");
    @(posedge clk_wr);
    rx_online <= 1'b1;
    count_edges_to_rise(1'b1, cfg_dx + 10, edges);
    check_value(edges - 1, cfg_dx + 2, "edges from rx_online to rx_link_up");
    check_idle_frame();
    credit_model = cfg_credit;

    for (idx = 0; idx < cmd_q.size(); idx++) begin
      insert_idle_gap();
      case (cmd_q[idx])
        "S": send_word(pid_q[idx], data_q[idx], 1'b0);
        "D": send_word(pid_q[idx], data_q[idx], 1'b1);
        "P": pop_word(pid_q[idx], data_q[idx]);
        default: abort_run("unknown command letter in stimulus file");
      endcase
    end

    // Dropped word must never surface
    if (ref_data.size() != 0) abort_run("accepted words were never popped");
    repeat (10) begin
      @(negedge clk_wr);
      check_value(dstrm_valid, 1'b0, "receive FIFO empty at end");
    end
    check_value(ustrm_credit, credit_model, "credit at end");
    $display("all tests passed");
    $finish;
  end

  initial begin : watchdog
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk_wr);
    $display("TIMEOUT at %0t: run did not finish within %0d cycles", $time, watchdog_cycles);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- verif/lpif_link_stimulus.txt
# C delay_x delay_y init_credit (decimal), given once before the commands
# S send, P pop and expect, D send at zero credit; columns: letter protid data (hex)
C 6 9 4
S 1 0123456789abcdef
S 2 fedcba9876543210
P 1 0123456789abcdef
P 2 fedcba9876543210
S 3 a5a5a5a55a5a5a5a
S 0 8000000000000001
S 1 7fffffffc0000000
S 2 00000007ffffffff
D 3 deadbeefcafef00d
P 3 a5a5a5a55a5a5a5a
P 0 8000000000000001
S 3 123456789abcdef0
P 1 7fffffffc0000000
P 2 00000007ffffffff
P 3 123456789abcdef0
S 0 0000000800000000
S 2 ffffffffffffffff
P 0 0000000800000000
P 2 ffffffffffffffff

//--- filelist.f
+incdir+source
source/lpif_link_pkg.sv
source/delay_timer.sv
source/link_sync_fsm.sv
source/tx_frame_packer.sv
source/rx_frame_unpacker.sv
source/lpif_link_top.sv
verif/tb_lpif_link.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the link layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_lpif_link -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "FAIL: Verilator build did not complete"
  exit 1
fi

output=$(./obj_dir/Vtb_lpif_link 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "FAIL: simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
  echo "PASS"
  exit 0
fi

echo "FAIL: pass message not found in simulation output"
exit 1
